//--- logic/backend_defines.svh
`ifndef BACKEND_DEFINES_SVH
`define BACKEND_DEFINES_SVH

// Datapath and PC width
`define BACKEND_XLEN 32
// Register file address width
`define BACKEND_RADDR_W 5
// Issue lanes, lane 0 is A and lane 1 is B
`define BACKEND_LANES 2
// Hardwired zero register
`define BACKEND_ZERO_REG 0

`endif

//--- logic/backend_pkg.sv
package backend_pkg;

`include "backend_defines.svh"

    typedef logic [`BACKEND_XLEN-1:0]    word_t;      // Data word or PC
    typedef logic [`BACKEND_RADDR_W-1:0] reg_addr_t;  // Register number

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_AND   = 4'd2,
        ALU_OR    = 4'd3,
        ALU_XOR   = 4'd4,
        ALU_SLL   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_SLT   = 4'd8,
        ALU_SLTU  = 4'd9,
        ALU_PASS2 = 4'd10   // Copy of source 2
    } alu_op_t;

    typedef enum logic {
        SRC1_REG = 1'b0,
        SRC1_PC  = 1'b1
    } src1_sel_t;

    typedef enum logic {
        SRC2_REG = 1'b0,
        SRC2_IMM = 1'b1
    } src2_sel_t;

endpackage

//--- logic/lane_ifs.sv
`timescale 1ns/1ps

// Issue slot from the forwarding block into one lane
interface issue_if;
    import backend_pkg::*;

    logic      valid;
    logic      ready;
    word_t     pc;
    alu_op_t   op;
    src1_sel_t src1_sel;
    src2_sel_t src2_sel;
    word_t     imm;
    logic      we;
    reg_addr_t waddr;
    word_t     opnd1;       // Already forwarded
    word_t     opnd2;

    modport source (output valid, pc, op, src1_sel, src2_sel, imm, we, waddr,
                    opnd1, opnd2, input ready);
    modport sink   (input valid, pc, op, src1_sel, src2_sel, imm, we, waddr,
                    opnd1, opnd2, output ready);
endinterface

// In-flight results of one lane, seen by the forwarding block
interface fwd_if;
    import backend_pkg::*;

    logic      mem_valid;
    logic      mem_we;
    reg_addr_t mem_waddr;
    word_t     mem_wdata;
    logic      wb_valid;
    logic      wb_we;
    reg_addr_t wb_waddr;
    word_t     wb_wdata;

    modport source (output mem_valid, mem_we, mem_waddr, mem_wdata,
                    wb_valid, wb_we, wb_waddr, wb_wdata);
    modport sink   (input mem_valid, mem_we, mem_waddr, mem_wdata,
                    wb_valid, wb_we, wb_waddr, wb_wdata);
endinterface

// WB stage of one lane towards the merge block
interface retire_if (input logic clk, input logic reset);
    import backend_pkg::*;

    logic      valid;
    logic      ready;
    logic      we;
    reg_addr_t waddr;
    word_t     wdata;
    word_t     pc;

    modport source (output valid, we, waddr, wdata, pc, input ready);
    modport sink   (input clk, reset, valid, we, waddr, wdata, pc, output ready);
endinterface

//--- logic/operand_forward.sv
`timescale 1ns/1ps
`include "backend_defines.svh"

module operand_forward (
    input  logic                  in_valid,
    output logic                  in_ready,
    input  backend_pkg::word_t    pc_a,
    input  backend_pkg::word_t    pc_b,
    input  backend_pkg::alu_op_t  alu_op_a,
    input  backend_pkg::alu_op_t  alu_op_b,
    input  backend_pkg::src1_sel_t src1_sel_a,
    input  backend_pkg::src1_sel_t src1_sel_b,
    input  backend_pkg::src2_sel_t src2_sel_a,
    input  backend_pkg::src2_sel_t src2_sel_b,
    input  backend_pkg::reg_addr_t raddr1_a,
    input  backend_pkg::reg_addr_t raddr1_b,
    input  backend_pkg::reg_addr_t raddr2_a,
    input  backend_pkg::reg_addr_t raddr2_b,
    input  backend_pkg::word_t    rdata1_a,
    input  backend_pkg::word_t    rdata1_b,
    input  backend_pkg::word_t    rdata2_a,
    input  backend_pkg::word_t    rdata2_b,
    input  backend_pkg::word_t    imm_a,
    input  backend_pkg::word_t    imm_b,
    input  logic                  rf_we_a,
    input  logic                  rf_we_b,
    input  backend_pkg::reg_addr_t waddr_a,
    input  backend_pkg::reg_addr_t waddr_b,
    issue_if.source               iss [`BACKEND_LANES],
    fwd_if.sink                   fwd [`BACKEND_LANES]
);
    import backend_pkg::*;

    localparam int NSRC = 2 * `BACKEND_LANES;   // Two sources per lane
    localparam int NENT = 2 * `BACKEND_LANES;   // MEM and WB entry per lane

    reg_addr_t              raddr_s [NSRC];
    word_t                  rdata_s [NSRC];
    word_t                  opnd_s  [NSRC];
    logic      [NENT-1:0]   ent_v;              // Index 0 has highest priority
    reg_addr_t              ent_addr [NENT];
    word_t                  ent_data [NENT];
    logic [`BACKEND_LANES-1:0] lane_ready;

    assign raddr_s = '{raddr1_a, raddr2_a, raddr1_b, raddr2_b};
    assign rdata_s = '{rdata1_a, rdata2_a, rdata1_b, rdata2_b};

    assign in_ready = &lane_ready;  // Lanes move in lockstep

    for (genvar l = 0; l < `BACKEND_LANES; l++) begin : g_lane
        // Younger lane outranks older one within the same stage
        assign ent_v[`BACKEND_LANES-1-l]       = fwd[l].mem_valid & fwd[l].mem_we;
        assign ent_addr[`BACKEND_LANES-1-l]    = fwd[l].mem_waddr;
        assign ent_data[`BACKEND_LANES-1-l]    = fwd[l].mem_wdata;
        assign ent_v[NENT-1-l]                 = fwd[l].wb_valid & fwd[l].wb_we;
        assign ent_addr[NENT-1-l]              = fwd[l].wb_waddr;
        assign ent_data[NENT-1-l]              = fwd[l].wb_wdata;

        assign lane_ready[l]  = iss[l].ready;
        assign iss[l].valid    = in_valid & in_ready;
        assign iss[l].pc       = (l == 0) ? pc_a : pc_b;
        assign iss[l].op       = (l == 0) ? alu_op_a : alu_op_b;
        assign iss[l].src1_sel = (l == 0) ? src1_sel_a : src1_sel_b;
        assign iss[l].src2_sel = (l == 0) ? src2_sel_a : src2_sel_b;
        assign iss[l].imm      = (l == 0) ? imm_a : imm_b;
        assign iss[l].we       = (l == 0) ? rf_we_a : rf_we_b;
        assign iss[l].waddr    = (l == 0) ? waddr_a : waddr_b;
        assign iss[l].opnd1    = opnd_s[2*l];
        assign iss[l].opnd2    = opnd_s[2*l+1];
    end

    for (genvar s = 0; s < NSRC; s++) begin : g_src
        always_comb begin
            opnd_s[s] = rdata_s[s];
            // Walk from lowest priority so the best match wins
            for (int e = NENT - 1; e >= 0; e--) begin
                if (ent_v[e] && (ent_addr[e] == raddr_s[s]) &&
                    (raddr_s[s] != reg_addr_t'(`BACKEND_ZERO_REG))) begin
                    opnd_s[s] = ent_data[e];
                end
            end
        end
    end

endmodule

//--- logic/exec_lane.sv
`timescale 1ns/1ps
`include "backend_defines.svh"

module exec_lane (
    input  logic      clk,
    input  logic      reset,
    issue_if.sink     iss,
    fwd_if.source     fwd,
    retire_if.source  ret
);
    import backend_pkg::*;

    word_t     src1;
    word_t     src2;
    word_t     alu_res;
    logic [4:0] shamt;
    logic      ex_we;

    logic      mem_valid;
    logic      mem_we;
    reg_addr_t mem_waddr;
    word_t     mem_wdata;
    word_t     mem_pc;
    logic      mem_ready;

    logic      wb_valid;
    logic      wb_we;
    reg_addr_t wb_waddr;
    word_t     wb_wdata;
    word_t     wb_pc;
    logic      wb_ready;

    assign src1  = (iss.src1_sel == SRC1_PC) ? iss.pc : iss.opnd1;
    assign src2  = (iss.src2_sel == SRC2_IMM) ? iss.imm : iss.opnd2;
    assign shamt = src2[4:0];
    assign ex_we = iss.we && (iss.waddr != reg_addr_t'(`BACKEND_ZERO_REG));  // r0 never written

    always_comb begin
        case (iss.op)
            ALU_ADD:   alu_res = src1 + src2;
            ALU_SUB:   alu_res = src1 - src2;
            ALU_AND:   alu_res = src1 & src2;
            ALU_OR:    alu_res = src1 | src2;
            ALU_XOR:   alu_res = src1 ^ src2;
            ALU_SLL:   alu_res = src1 << shamt;
            ALU_SRL:   alu_res = src1 >> shamt;
            ALU_SRA:   alu_res = word_t'($signed(src1) >>> shamt);
            ALU_SLT:   alu_res = word_t'($signed(src1) < $signed(src2));
            ALU_SLTU:  alu_res = word_t'(src1 < src2);
            ALU_PASS2: alu_res = src2;
            default:   alu_res = '0;
        endcase
    end

    // A stage can take new data when empty or draining this cycle
    assign wb_ready  = !wb_valid || ret.ready;
    assign mem_ready = !mem_valid || wb_ready;
    assign iss.ready = mem_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_valid <= 1'b0;
            wb_valid  <= 1'b0;
        end else begin
            if (mem_ready) mem_valid <= iss.valid;
            if (wb_ready)  wb_valid  <= mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (iss.valid && mem_ready) begin
            mem_we    <= ex_we;
            mem_waddr <= iss.waddr;
            mem_wdata <= alu_res;
            mem_pc    <= iss.pc;
        end
        if (mem_valid && wb_ready) begin
            wb_we    <= mem_we;
            wb_waddr <= mem_waddr;
            wb_wdata <= mem_wdata;
            wb_pc    <= mem_pc;
        end
    end

    assign fwd.mem_valid = mem_valid;
    assign fwd.mem_we    = mem_we;
    assign fwd.mem_waddr = mem_waddr;
    assign fwd.mem_wdata = mem_wdata;
    assign fwd.wb_valid  = wb_valid;
    assign fwd.wb_we     = wb_we;
    assign fwd.wb_waddr  = wb_waddr;
    assign fwd.wb_wdata  = wb_wdata;

    assign ret.valid = wb_valid;
    assign ret.we    = wb_we;
    assign ret.waddr = wb_waddr;
    assign ret.wdata = wb_wdata;
    assign ret.pc    = wb_pc;

    // Stalled writeback must not change under the consumer
    wb_hold_stable: assert property (@(posedge clk) disable iff (reset)
        wb_valid && !ret.ready |=> wb_valid && $stable({wb_we, wb_waddr, wb_wdata, wb_pc}))
        else $error("WB payload changed while stalled");

endmodule

//--- logic/retire_merge.sv
`timescale 1ns/1ps
`include "backend_defines.svh"

module retire_merge (
    retire_if.sink                  ret [`BACKEND_LANES],
    input  logic                    wb_ready,
    output logic                    wb_valid,
    output logic                    wb_we_a,
    output logic                    wb_we_b,
    output backend_pkg::reg_addr_t  wb_waddr_a,
    output backend_pkg::reg_addr_t  wb_waddr_b,
    output backend_pkg::word_t      wb_wdata_a,
    output backend_pkg::word_t      wb_wdata_b,
    output backend_pkg::word_t      wb_pc_a,
    output backend_pkg::word_t      wb_pc_b
);
    logic same_dst;     // Both lanes target one register

    for (genvar l = 0; l < `BACKEND_LANES; l++) begin : g_ready
        assign ret[l].ready = wb_ready;
    end

    assign wb_valid = ret[0].valid & ret[1].valid;

    assign same_dst = ret[1].we && (ret[1].waddr == ret[0].waddr);

    assign wb_we_a    = ret[0].we && !same_dst;     // Younger write survives
    assign wb_waddr_a = ret[0].waddr;
    assign wb_wdata_a = ret[0].wdata;
    assign wb_pc_a    = ret[0].pc;

    assign wb_we_b    = ret[1].we;
    assign wb_waddr_b = ret[1].waddr;
    assign wb_wdata_b = ret[1].wdata;
    assign wb_pc_b    = ret[1].pc;

    // Lanes were issued together and must retire together
    lanes_in_step: assert property (@(posedge ret[0].clk) disable iff (ret[0].reset)
        ret[0].valid == ret[1].valid)
        else $error("Lane WB valids diverged");

endmodule

//--- logic/dual_issue_backend.sv
`timescale 1ns/1ps
`include "backend_defines.svh"

module dual_issue_backend (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  backend_pkg::word_t      pc_a,
    input  backend_pkg::word_t      pc_b,
    input  backend_pkg::alu_op_t    alu_op_a,
    input  backend_pkg::alu_op_t    alu_op_b,
    input  backend_pkg::src1_sel_t  src1_sel_a,
    input  backend_pkg::src1_sel_t  src1_sel_b,
    input  backend_pkg::src2_sel_t  src2_sel_a,
    input  backend_pkg::src2_sel_t  src2_sel_b,
    input  backend_pkg::reg_addr_t  raddr1_a,
    input  backend_pkg::reg_addr_t  raddr1_b,
    input  backend_pkg::reg_addr_t  raddr2_a,
    input  backend_pkg::reg_addr_t  raddr2_b,
    input  backend_pkg::word_t      rdata1_a,
    input  backend_pkg::word_t      rdata1_b,
    input  backend_pkg::word_t      rdata2_a,
    input  backend_pkg::word_t      rdata2_b,
    input  backend_pkg::word_t      imm_a,
    input  backend_pkg::word_t      imm_b,
    input  logic                    rf_we_a,
    input  logic                    rf_we_b,
    input  backend_pkg::reg_addr_t  waddr_a,
    input  backend_pkg::reg_addr_t  waddr_b,
    output logic                    wb_valid,
    input  logic                    wb_ready,
    output logic                    wb_we_a,
    output logic                    wb_we_b,
    output backend_pkg::reg_addr_t  wb_waddr_a,
    output backend_pkg::reg_addr_t  wb_waddr_b,
    output backend_pkg::word_t      wb_wdata_a,
    output backend_pkg::word_t      wb_wdata_b,
    output backend_pkg::word_t      wb_pc_a,
    output backend_pkg::word_t      wb_pc_b
);
    issue_if  iss_bus [`BACKEND_LANES] ();
    fwd_if    fwd_bus [`BACKEND_LANES] ();
    retire_if ret_bus [`BACKEND_LANES] (.clk(clk), .reset(reset));

    operand_forward u_forward (
        .in_valid   (in_valid),   .in_ready   (in_ready),
        .pc_a       (pc_a),       .pc_b       (pc_b),
        .alu_op_a   (alu_op_a),   .alu_op_b   (alu_op_b),
        .src1_sel_a (src1_sel_a), .src1_sel_b (src1_sel_b),
        .src2_sel_a (src2_sel_a), .src2_sel_b (src2_sel_b),
        .raddr1_a   (raddr1_a),   .raddr1_b   (raddr1_b),
        .raddr2_a   (raddr2_a),   .raddr2_b   (raddr2_b),
        .rdata1_a   (rdata1_a),   .rdata1_b   (rdata1_b),
        .rdata2_a   (rdata2_a),   .rdata2_b   (rdata2_b),
        .imm_a      (imm_a),      .imm_b      (imm_b),
        .rf_we_a    (rf_we_a),    .rf_we_b    (rf_we_b),
        .waddr_a    (waddr_a),    .waddr_b    (waddr_b),
        .iss        (iss_bus),
        .fwd        (fwd_bus)
    );

    for (genvar l = 0; l < `BACKEND_LANES; l++) begin : g_lane
        exec_lane u_lane (
            .clk   (clk),
            .reset (reset),
            .iss   (iss_bus[l]),
            .fwd   (fwd_bus[l]),
            .ret   (ret_bus[l])
        );
    end

    retire_merge u_merge (
        .ret        (ret_bus),
        .wb_ready   (wb_ready),
        .wb_valid   (wb_valid),
        .wb_we_a    (wb_we_a),    .wb_we_b    (wb_we_b),
        .wb_waddr_a (wb_waddr_a), .wb_waddr_b (wb_waddr_b),
        .wb_wdata_a (wb_wdata_a), .wb_wdata_b (wb_wdata_b),
        .wb_pc_a    (wb_pc_a),    .wb_pc_b    (wb_pc_b)
    );

endmodule

//--- testbench/backend_tb.sv
`timescale 1ns/1ps
`include "backend_defines.svh"

module backend_tb;
    import backend_pkg::*;

    localparam int NREGS = 1 << `BACKEND_RADDR_W;

    typedef struct packed {
        logic      we_a;
        reg_addr_t waddr_a;
        word_t     wdata_a;
        word_t     pc_a;
        logic      we_b;
        reg_addr_t waddr_b;
        word_t     wdata_b;
        word_t     pc_b;
    } pair_t;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        in_valid = 1'b0;
    logic        in_ready;
    logic        wb_valid;
    logic        wb_ready = 1'b1;
    logic        random_ready = 1'b0;   // Randomize wb_ready every cycle
    logic [31:0] rng = 32'd96306;
    word_t       pc_next = 32'h0000_1000;
    int          i;

    word_t     pc [2];
    alu_op_t   op [2];
    src1_sel_t s1 [2];
    src2_sel_t s2 [2];
    reg_addr_t ra1 [2];
    reg_addr_t ra2 [2];
    word_t     imm [2];
    logic      we [2];
    reg_addr_t wa [2];

    word_t     rf [NREGS];      // Retired state, answers the read ports
    word_t     spec [NREGS];    // State after every accepted pair
    pair_t     expected [$];

    logic      wb_we_a, wb_we_b;
    reg_addr_t wb_waddr_a, wb_waddr_b;
    word_t     wb_wdata_a, wb_wdata_b;
    word_t     wb_pc_a, wb_pc_b;

    dual_issue_backend dut0 (
        .clk        (clk),          .reset      (reset),
        .in_valid   (in_valid),     .in_ready   (in_ready),
        .pc_a       (pc[0]),        .pc_b       (pc[1]),
        .alu_op_a   (op[0]),        .alu_op_b   (op[1]),
        .src1_sel_a (s1[0]),        .src1_sel_b (s1[1]),
        .src2_sel_a (s2[0]),        .src2_sel_b (s2[1]),
        .raddr1_a   (ra1[0]),       .raddr1_b   (ra1[1]),
        .raddr2_a   (ra2[0]),       .raddr2_b   (ra2[1]),
        .rdata1_a   (rf[ra1[0]]),   .rdata1_b   (rf[ra1[1]]),
        .rdata2_a   (rf[ra2[0]]),   .rdata2_b   (rf[ra2[1]]),
        .imm_a      (imm[0]),       .imm_b      (imm[1]),
        .rf_we_a    (we[0]),        .rf_we_b    (we[1]),
        .waddr_a    (wa[0]),        .waddr_b    (wa[1]),
        .wb_valid   (wb_valid),     .wb_ready   (wb_ready),
        .wb_we_a    (wb_we_a),      .wb_we_b    (wb_we_b),
        .wb_waddr_a (wb_waddr_a),   .wb_waddr_b (wb_waddr_b),
        .wb_wdata_a (wb_wdata_a),   .wb_wdata_b (wb_wdata_b),
        .wb_pc_a    (wb_pc_a),      .wb_pc_b    (wb_pc_b)
    );

    always #2 clk = ~clk;

    function logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function word_t rand_word();
        rng = xorshift(rng);
        return rng;
    endfunction

    // Start value of each register, r0 stays zero
    function word_t init_value(int n);
        return (n == 0) ? '0 : word_t'(n) * 32'h9e37_79b9 + word_t'(n << 4);
    endfunction

    function word_t alu_model(alu_op_t f, word_t a, word_t b);
        case (f)
            ALU_ADD:   return a + b;
            ALU_SUB:   return a - b;
            ALU_AND:   return a & b;
            ALU_OR:    return a | b;
            ALU_XOR:   return a ^ b;
            ALU_SLL:   return a << b[4:0];
            ALU_SRL:   return a >> b[4:0];
            ALU_SRA:   return word_t'($signed(a) >>> b[4:0]);
            ALU_SLT:   return ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
            ALU_SLTU:  return (a < b) ? word_t'(1) : word_t'(0);
            ALU_PASS2: return b;
            default:   return '0;
        endcase
    endfunction

    task fail_now(string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped at the first failed check");
    endtask

    task check_word(word_t got, word_t exp, string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            fail_now("Word mismatch");
        end
    endtask

    task check_addr(reg_addr_t got, reg_addr_t exp, string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            fail_now("Register address mismatch");
        end
    endtask

    task check_bit(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            fail_now("Control bit mismatch");
        end
    endtask

    task set_lane(int l, alu_op_t f, src1_sel_t a_sel, src2_sel_t b_sel, reg_addr_t r1,
                  reg_addr_t r2, word_t iv, logic w, reg_addr_t d);
        op[l]  = f;
        s1[l]  = a_sel;
        s2[l]  = b_sel;
        ra1[l] = r1;
        ra2[l] = r2;
        imm[l] = iv;
        we[l]  = w;
        wa[l]  = d;
        pc[l]  = pc_next;
        pc_next = pc_next + 4;
    endtask

    function word_t lane_result(int l);
        word_t a;
        word_t b;
        a = (s1[l] == SRC1_PC) ? pc[l] : spec[ra1[l]];     // Pre-pair state for both lanes
        b = (s2[l] == SRC2_IMM) ? imm[l] : spec[ra2[l]];
        return alu_model(op[l], a, b);
    endfunction

    task record_pair();
        pair_t p;
        logic  we_a_eff;
        logic  we_b_eff;
        we_a_eff  = we[0] && (wa[0] != '0);
        we_b_eff  = we[1] && (wa[1] != '0);
        p.wdata_a = lane_result(0);
        p.wdata_b = lane_result(1);
        p.waddr_a = wa[0];
        p.waddr_b = wa[1];
        p.pc_a    = pc[0];
        p.pc_b    = pc[1];
        p.we_a    = we_a_eff && !(we_b_eff && (wa[1] == wa[0]));   // Lane B wins
        p.we_b    = we_b_eff;
        if (we_a_eff) spec[wa[0]] = p.wdata_a;
        if (we_b_eff) spec[wa[1]] = p.wdata_b;
        expected.push_back(p);
    endtask

    task step_ready();
        if (random_ready) wb_ready = (rand_word() % 4) != 0;
    endtask

    task issue_pair();
        int n;
        in_valid = 1'b1;
        for (n = 0; n < 100; n++) begin
            @(negedge clk);
            if (in_ready) begin
                record_pair();      // Handshake completes on the coming edge
                @(posedge clk);
                #1;
                in_valid = 1'b0;
                step_ready();
                return;
            end
            @(posedge clk);
            #1;
            step_ready();
        end
        fail_now("Timeout: in_ready stayed low for 100 cycles");
    endtask

    task drain();
        int n;
        for (n = 0; n < 300; n++) begin
            if (expected.size() == 0) return;
            @(posedge clk);
            #1;
            step_ready();
        end
        fail_now("Timeout: expected writeback pairs did not retire");
    endtask

    // Idle state, then one independent pair
    task idle_then_single_pair();
        check_bit(wb_valid, 1'b0, "wb_valid after reset");
        check_bit(in_ready, 1'b1, "in_ready after reset");
        set_lane(0, ALU_ADD, SRC1_REG, SRC2_REG, 5'd1, 5'd2, '0, 1'b1, 5'd3);
        set_lane(1, ALU_ADD, SRC1_REG, SRC2_IMM, 5'd4, '0, 32'd100, 1'b1, 5'd5);
        issue_pair();
        drain();
    endtask

    // Every ALU operation, register sources in A and PC plus immediate in B
    task alu_op_sweep();
        int k;
        for (k = 0; k < 11; k++) begin
            set_lane(0, alu_op_t'(4'(k)), SRC1_REG, SRC2_REG, reg_addr_t'(k + 1),
                     reg_addr_t'(k + 12), '0, 1'b1, reg_addr_t'(k + 20));
            set_lane(1, alu_op_t'(4'(k)), SRC1_PC, SRC2_IMM, reg_addr_t'(k + 2), '0,
                     32'hffff_fff0 + word_t'(k), 1'b1, 5'd31);
            issue_pair();
        end
        drain();
    endtask

    // Dependent chain over three registers, operands come from MEM and WB
    task forwarding_chain();
        int k;
        for (k = 0; k < 8; k++) begin
            set_lane(0, ALU_ADD, SRC1_REG, SRC2_REG, 5'd5, 5'd6, '0, 1'b1,
                     reg_addr_t'(5 + k % 3));
            set_lane(1, ALU_SUB, SRC1_REG, SRC2_IMM, reg_addr_t'(5 + (k + 1) % 3), '0,
                     word_t'(k), 1'b1, reg_addr_t'(5 + (k + 2) % 3));
            issue_pair();
        end
        drain();
    endtask

    // Back-pressure fills both stages
    task backpressure_stall();
        wb_ready = 1'b0;
        set_lane(0, ALU_XOR, SRC1_REG, SRC2_REG, 5'd7, 5'd8, '0, 1'b1, 5'd9);
        set_lane(1, ALU_OR, SRC1_REG, SRC2_IMM, 5'd9, '0, 32'h0f0f, 1'b1, 5'd10);
        issue_pair();
        check_bit(in_ready, 1'b1, "in_ready with one pair in flight");
        set_lane(0, ALU_ADD, SRC1_REG, SRC2_REG, 5'd9, 5'd10, '0, 1'b1, 5'd11);
        set_lane(1, ALU_SLL, SRC1_REG, SRC2_IMM, 5'd9, '0, 32'd3, 1'b1, 5'd12);
        issue_pair();
        check_bit(in_ready, 1'b0, "in_ready with two pairs in flight");
        repeat (3) begin
            @(posedge clk);
            #1;
        end
        check_bit(in_ready, 1'b0, "in_ready while stalled");
        check_bit(wb_valid, 1'b1, "wb_valid while stalled");
        wb_ready = 1'b1;
        drain();
    endtask

    // Same destination in both lanes, then writes to r0
    task write_conflicts();
        set_lane(0, ALU_ADD, SRC1_REG, SRC2_IMM, 5'd1, '0, 32'd11, 1'b1, 5'd13);
        set_lane(1, ALU_OR, SRC1_REG, SRC2_IMM, 5'd2, '0, 32'd22, 1'b1, 5'd13);
        issue_pair();
        set_lane(0, ALU_PASS2, SRC1_REG, SRC2_IMM, 5'd0, '0, 32'hdead, 1'b1, 5'd0);
        set_lane(1, ALU_ADD, SRC1_REG, SRC2_REG, 5'd13, 5'd0, '0, 1'b1, 5'd0);
        issue_pair();
        set_lane(0, ALU_ADD, SRC1_REG, SRC2_REG, 5'd0, 5'd13, '0, 1'b1, 5'd14);
        set_lane(1, ALU_SUB, SRC1_REG, SRC2_REG, 5'd13, 5'd0, '0, 1'b1, 5'd15);
        issue_pair();
        drain();
    endtask

    task random_pairs(int count);
        int          k;
        int          l;
        logic [31:0] r;
        for (k = 0; k < count; k++) begin
            for (l = 0; l < 2; l++) begin
                r = rand_word();
                // Few registers so hazards happen often
                set_lane(l, alu_op_t'(4'(r % 11)), src1_sel_t'(r[4]), src2_sel_t'(r[5]),
                         reg_addr_t'(r[8:6]), reg_addr_t'(r[11:9]), rand_word(),
                         r[13:12] != 2'b00, reg_addr_t'(r[16:14]));
            end
            issue_pair();
        end
        drain();
    endtask

    // Checks each retired pair and applies it to the read-side model
    initial begin : retire_monitor
        pair_t p;
        int    n;
        for (n = 0; n < NREGS; n++) rf[n] = init_value(n);
        forever begin
            @(negedge clk);
            if (!reset && wb_valid && wb_ready) begin
                if (expected.size() == 0) fail_now("A pair retired that was never issued");
                p = expected.pop_front();
                check_bit(wb_we_a, p.we_a, "lane A wb_we");
                check_addr(wb_waddr_a, p.waddr_a, "lane A wb_waddr");
                check_word(wb_wdata_a, p.wdata_a, "lane A wb_wdata");
                check_word(wb_pc_a, p.pc_a, "lane A wb_pc");
                check_bit(wb_we_b, p.we_b, "lane B wb_we");
                check_addr(wb_waddr_b, p.waddr_b, "lane B wb_waddr");
                check_word(wb_wdata_b, p.wdata_b, "lane B wb_wdata");
                check_word(wb_pc_b, p.pc_b, "lane B wb_pc");
                @(posedge clk);
                #1;
                if (p.we_a && p.waddr_a != '0) rf[p.waddr_a] = p.wdata_a;  // Older first
                if (p.we_b && p.waddr_b != '0) rf[p.waddr_b] = p.wdata_b;
            end
        end
    end

    initial begin
        for (i = 0; i < NREGS; i++) spec[i] = init_value(i);
        set_lane(0, ALU_ADD, SRC1_REG, SRC2_REG, '0, '0, '0, 1'b0, '0);
        set_lane(1, ALU_ADD, SRC1_REG, SRC2_REG, '0, '0, '0, 1'b0, '0);
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        idle_then_single_pair();
        alu_op_sweep();
        forwarding_chain();
        backpressure_stall();
        write_conflicts();

        // Random traffic with random back-pressure
        random_ready = 1'b1;
        random_pairs(300);
        random_ready = 1'b0;
        wb_ready = 1'b1;

        if (expected.size() == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            fail_now("Pairs were still expected at the end of the run");
        end
    end

endmodule

//--- list.f
+incdir+logic
logic/backend_pkg.sv
logic/lane_ifs.sv
logic/operand_forward.sv
logic/exec_lane.sv
logic/retire_merge.sv
logic/dual_issue_backend.sv
testbench/backend_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f list.f \
    --top-module backend_tb --Mdir obj_dir -o backend_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/backend_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0
